// ==== src/ros2_cfg_pkg.sv ====
package ros2_cfg_pkg;

    // buffer geometry.
    localparam int RXBUF_AWIDTH = 6;
    localparam int TXBUF_AWIDTH = 6;
    localparam int WORD_WIDTH   = 32;

    // the UDP size sits in the upper half of this receive word.
    localparam int                      SIZE_WIDTH     = 16;
    localparam logic [RXBUF_AWIDTH-1:0] SIZE_WORD_ADDR = RXBUF_AWIDTH'(1);

    // size thresholds for the LEDs.
    localparam logic [SIZE_WIDTH-1:0] LED_R_MAX = 16'd10;
    localparam logic [SIZE_WIDTH-1:0] LED_G_MAX = 16'd20;

    // fixed transmit record served to the engine.
    localparam int TX_RECORD_LEN = 5;
    localparam logic [WORD_WIDTH-1:0] TX_RECORD [TX_RECORD_LEN] = '{
        32'h0a01a8c0,
        32'h045704d2,
        32'h00000007,
        32'h626f6f66,
        32'h000a7261
    };

endpackage

// ==== src/buf_arb_pkg.sv ====
package buf_arb_pkg;

    // holder of the shared application data.
    typedef enum logic [1:0] {
        GRANT_NONE   = 2'b00,
        GRANT_ENGINE = 2'b01,
        GRANT_HOST   = 2'b10
    } app_grant_t;

    // owner of a two-sided buffer.
    typedef enum logic {
        OWNER_ENGINE = 1'b0,
        OWNER_HOST   = 1'b1
    } buf_owner_t;

endpackage

// ==== src/rxbuf_wr_if.sv ====
`timescale 1ns/1ps

interface rxbuf_wr_if
    import ros2_cfg_pkg::*;
();

    logic [RXBUF_AWIDTH-1:0] addr;
    logic                    ce;
    logic                    we;
    logic [WORD_WIDTH-1:0]   wdata;

    // engine side writes the buffer.
    modport engine (
        output addr,
        output ce,
        output we,
        output wdata
    );

    // host side snoops the writes.
    modport host (
        input addr,
        input ce,
        input we,
        input wdata
    );

endinterface

// ==== src/app_data_arbiter.sv ====
`timescale 1ns/1ps

module app_data_arbiter
    import buf_arb_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic ip_req,
    input  logic ip_rel,
    input  logic cpu_req,
    input  logic cpu_rel,
    output logic ip_grant,
    output logic cpu_grant
);

    app_grant_t grant_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant_q <= GRANT_NONE;
        end else begin
            case (grant_q)
                GRANT_NONE: begin
                    // engine wins a tie.
                    if (ip_req) begin
                        grant_q <= GRANT_ENGINE;
                    end else if (cpu_req) begin
                        grant_q <= GRANT_HOST;
                    end
                end
                GRANT_ENGINE: begin
                    if (ip_rel) begin
                        grant_q <= GRANT_NONE;
                    end
                end
                GRANT_HOST: begin
                    if (cpu_rel) begin
                        grant_q <= GRANT_NONE;
                    end
                end
                default: begin
                    grant_q <= GRANT_NONE;
                end
            endcase
        end
    end

    assign ip_grant  = (grant_q == GRANT_ENGINE);
    assign cpu_grant = (grant_q == GRANT_HOST);

endmodule

// ==== src/buf_owner_arbiter.sv ====
`timescale 1ns/1ps

module buf_owner_arbiter
    import buf_arb_pkg::*;
#(
    parameter buf_owner_t RESET_OWNER = OWNER_ENGINE
) (
    input  logic clk,
    input  logic rst_n,
    input  logic ip_rel,
    input  logic cpu_rel,
    output logic ip_grant,
    output logic cpu_grant
);

    buf_owner_t owner_q;

    // only the current owner can give the buffer away.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner_q <= RESET_OWNER;
        end else begin
            case (owner_q)
                OWNER_ENGINE: begin
                    if (ip_rel) begin
                        owner_q <= OWNER_HOST;
                    end
                end
                OWNER_HOST: begin
                    if (cpu_rel) begin
                        owner_q <= OWNER_ENGINE;
                    end
                end
                default: begin
                    owner_q <= RESET_OWNER;
                end
            endcase
        end
    end

    assign ip_grant  = (owner_q == OWNER_ENGINE);
    assign cpu_grant = (owner_q == OWNER_HOST);

endmodule

// ==== src/host_tx_agent.sv ====
`timescale 1ns/1ps

module host_tx_agent
    import ros2_cfg_pkg::*;
#(
    parameter int TX_PERIOD_LOG2 = 6
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [TXBUF_AWIDTH-1:0] txbuf_addr,
    output logic                    cpu_rel,
    output logic [WORD_WIDTH-1:0]   txbuf_rdata
);

    localparam int REC_IDX_W = $clog2(TX_RECORD_LEN);

    logic [TX_PERIOD_LOG2:0] tx_cnt;
    logic [REC_IDX_W-1:0]    rec_idx;
    logic                    rec_hit;

    // period timer, one release pulse each time the top bit comes up.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_cnt  <= '0;
            cpu_rel <= 1'b0;
        end else begin
            if (tx_cnt[TX_PERIOD_LOG2]) begin
                tx_cnt  <= '0;
                cpu_rel <= 1'b1;
            end else begin
                tx_cnt  <= tx_cnt + 1'b1;
                cpu_rel <= 1'b0;
            end
        end
    end

    assign rec_hit = (txbuf_addr < TXBUF_AWIDTH'(TX_RECORD_LEN));
    assign rec_idx = txbuf_addr[REC_IDX_W-1:0];

    // registered record lookup, zero past the last word.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            txbuf_rdata <= '0;
        end else if (rec_hit) begin
            txbuf_rdata <= TX_RECORD[rec_idx];
        end else begin
            txbuf_rdata <= '0;
        end
    end

endmodule

// ==== src/host_rx_agent.sv ====
`timescale 1ns/1ps

module host_rx_agent
    import ros2_cfg_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cpu_grant,
    rxbuf_wr_if.host        wr,
    output logic            cpu_rel,
    output logic            led_r,
    output logic            led_g,
    output logic            led_b
);

    logic [SIZE_WIDTH-1:0] last_rx_size;
    logic                  size_wr;

    // header write carrying the UDP size.
    assign size_wr = wr.ce && wr.we && (wr.addr == SIZE_WORD_ADDR);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cpu_rel      <= 1'b0;
            last_rx_size <= '0;
        end else begin
            // hand the buffer straight back.
            cpu_rel <= cpu_grant;
            if (size_wr) begin
                last_rx_size <= wr.wdata[WORD_WIDTH-1 -: SIZE_WIDTH];
            end
        end
    end

    // zero size lights nothing.
    assign led_r = (last_rx_size != '0) && (last_rx_size <= LED_R_MAX);
    assign led_g = (last_rx_size > LED_R_MAX) && (last_rx_size <= LED_G_MAX);
    assign led_b = (last_rx_size > LED_G_MAX);

endmodule

// ==== src/ros2_buf_ctrl_top.sv ====
`timescale 1ns/1ps

module ros2_buf_ctrl_top
    import ros2_cfg_pkg::*;
    import buf_arb_pkg::*;
#(
    parameter int TX_PERIOD_LOG2 = 6
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    app_data_ip_req,
    input  logic                    app_data_ip_rel,
    input  logic                    app_data_cpu_req,
    input  logic                    app_data_cpu_rel,
    output logic                    app_data_ip_grant,
    output logic                    app_data_cpu_grant,

    input  logic                    rxbuf_ip_rel,
    input  logic [RXBUF_AWIDTH-1:0] rxbuf_addr,
    input  logic                    rxbuf_ce,
    input  logic                    rxbuf_we,
    input  logic [WORD_WIDTH-1:0]   rxbuf_wdata,
    output logic                    rxbuf_ip_grant,

    input  logic                    txbuf_ip_rel,
    input  logic [TXBUF_AWIDTH-1:0] txbuf_addr,
    output logic                    txbuf_ip_grant,
    output logic [WORD_WIDTH-1:0]   txbuf_rdata,

    output logic                    led_r,
    output logic                    led_g,
    output logic                    led_b
);

    logic rxbuf_cpu_rel;
    logic rxbuf_cpu_grant;
    logic txbuf_cpu_rel;

    rxbuf_wr_if rxbuf_wr ();

    // engine write port onto the interface.
    assign rxbuf_wr.addr  = rxbuf_addr;
    assign rxbuf_wr.ce    = rxbuf_ce;
    assign rxbuf_wr.we    = rxbuf_we;
    assign rxbuf_wr.wdata = rxbuf_wdata;

    app_data_arbiter app_data_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .ip_req   (app_data_ip_req),
        .ip_rel   (app_data_ip_rel),
        .cpu_req  (app_data_cpu_req),
        .cpu_rel  (app_data_cpu_rel),
        .ip_grant (app_data_ip_grant),
        .cpu_grant(app_data_cpu_grant)
    );

    buf_owner_arbiter #(
        .RESET_OWNER(OWNER_ENGINE)
    ) rxbuf_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .ip_rel   (rxbuf_ip_rel),
        .cpu_rel  (rxbuf_cpu_rel),
        .ip_grant (rxbuf_ip_grant),
        .cpu_grant(rxbuf_cpu_grant)
    );

    // host starts out holding the transmit buffer.
    buf_owner_arbiter #(
        .RESET_OWNER(OWNER_HOST)
    ) txbuf_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .ip_rel   (txbuf_ip_rel),
        .cpu_rel  (txbuf_cpu_rel),
        .ip_grant (txbuf_ip_grant),
        .cpu_grant()
    );

    host_tx_agent #(
        .TX_PERIOD_LOG2(TX_PERIOD_LOG2)
    ) tx_agent (
        .clk        (clk),
        .rst_n      (rst_n),
        .txbuf_addr (txbuf_addr),
        .cpu_rel    (txbuf_cpu_rel),
        .txbuf_rdata(txbuf_rdata)
    );

    host_rx_agent rx_agent (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu_grant(rxbuf_cpu_grant),
        .wr       (rxbuf_wr.host),
        .cpu_rel  (rxbuf_cpu_rel),
        .led_r    (led_r),
        .led_g    (led_g),
        .led_b    (led_b)
    );

endmodule

// ==== sim/buf_ctrl_props.sv ====
`timescale 1ns/1ps

module buf_ctrl_props
    import buf_arb_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input app_grant_t grant_state,
    input logic       ip_grant,
    input logic       cpu_grant,
    input logic       ip_rel,
    input logic       cpu_rel,
    input logic       pulse
);

    // application data never held by both sides.
    grant_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(ip_grant && cpu_grant))
        else $error("application data granted to engine and host together");

    // a holder keeps the grant until its own release.
    engine_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (grant_state == GRANT_ENGINE) && !ip_rel |=> (grant_state == GRANT_ENGINE))
        else $error("engine lost the application data without a release");

    host_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (grant_state == GRANT_HOST) && !cpu_rel |=> (grant_state == GRANT_HOST))
        else $error("host lost the application data without a release");

    // no direct hand-over, always through NONE.
    via_none: assert property (@(posedge clk) disable iff (!rst_n)
        (grant_state != GRANT_NONE) |=>
            (grant_state == GRANT_NONE) || (grant_state == $past(grant_state)))
        else $error("application data passed between holders without NONE");

    // timer release is a single-cycle pulse.
    pulse_width: assert property (@(posedge clk) disable iff (!rst_n)
        pulse |=> !pulse)
        else $error("transmit host release wider than one cycle");

endmodule

bind app_data_arbiter buf_ctrl_props app_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .grant_state(grant_q),
    .ip_grant   (ip_grant),
    .cpu_grant  (cpu_grant),
    .ip_rel     (ip_rel),
    .cpu_rel    (cpu_rel),
    .pulse      (1'b0)
);

bind host_tx_agent buf_ctrl_props tx_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .grant_state(buf_arb_pkg::GRANT_NONE),
    .ip_grant   (1'b0),
    .cpu_grant  (1'b0),
    .ip_rel     (1'b0),
    .cpu_rel    (1'b0),
    .pulse      (cpu_rel)
);

// ==== sim/tb_top.sv ====
`timescale 1ns/1ps

module tb_top
    import ros2_cfg_pkg::*;
    import buf_arb_pkg::*;
();

    localparam int CLK_PERIOD     = 4;
    localparam int TX_PERIOD_LOG2 = 6;
    localparam int TX_PERIOD      = (1 << TX_PERIOD_LOG2) + 1;

    localparam int N_APP      = 300;
    localparam int N_RX       = 200;
    localparam int N_TX       = 320;
    localparam int N_REC      = 150;
    localparam int N_LED      = 200;
    localparam int TIMEOUT_NS = (3 + N_APP + N_RX + N_TX + N_REC + N_LED + 100) * CLK_PERIOD;

    logic                    clk;
    logic                    rst_n;
    logic                    app_data_ip_req;
    logic                    app_data_ip_rel;
    logic                    app_data_cpu_req;
    logic                    app_data_cpu_rel;
    logic                    app_data_ip_grant;
    logic                    app_data_cpu_grant;
    logic                    rxbuf_ip_rel;
    logic [RXBUF_AWIDTH-1:0] rxbuf_addr;
    logic                    rxbuf_ce;
    logic                    rxbuf_we;
    logic [WORD_WIDTH-1:0]   rxbuf_wdata;
    logic                    rxbuf_ip_grant;
    logic                    txbuf_ip_rel;
    logic [TXBUF_AWIDTH-1:0] txbuf_addr;
    logic                    txbuf_ip_grant;
    logic [WORD_WIDTH-1:0]   txbuf_rdata;
    logic                    led_r;
    logic                    led_g;
    logic                    led_b;

    integer seed = 32'h287;
    int     errors;
    int     test_errors;
    int     tests_run;
    int     tests_failed;

    // reference model state.
    app_grant_t            m_app;
    logic                  m_rx_eng;
    logic                  m_rx_host_rel;
    logic                  m_tx_eng;
    int                    m_edges;
    logic [WORD_WIDTH-1:0] m_rdata;
    logic [SIZE_WIDTH-1:0] m_size;

    ros2_buf_ctrl_top #(
        .TX_PERIOD_LOG2(TX_PERIOD_LOG2)
    ) UUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .app_data_ip_req   (app_data_ip_req),
        .app_data_ip_rel   (app_data_ip_rel),
        .app_data_cpu_req  (app_data_cpu_req),
        .app_data_cpu_rel  (app_data_cpu_rel),
        .app_data_ip_grant (app_data_ip_grant),
        .app_data_cpu_grant(app_data_cpu_grant),
        .rxbuf_ip_rel      (rxbuf_ip_rel),
        .rxbuf_addr        (rxbuf_addr),
        .rxbuf_ce          (rxbuf_ce),
        .rxbuf_we          (rxbuf_we),
        .rxbuf_wdata       (rxbuf_wdata),
        .rxbuf_ip_grant    (rxbuf_ip_grant),
        .txbuf_ip_rel      (txbuf_ip_rel),
        .txbuf_addr        (txbuf_addr),
        .txbuf_ip_grant    (txbuf_ip_grant),
        .txbuf_rdata       (txbuf_rdata),
        .led_r             (led_r),
        .led_g             (led_g),
        .led_b             (led_b)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired at %0t, the tests did not complete", $time);
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic one_in(input int n);
        logic [31:0] r;
        r = rand_word();
        return (r % n) == 0;
    endfunction

    // expected {red, green, blue} for a captured size.
    function automatic logic [2:0] expected_leds(input logic [SIZE_WIDTH-1:0] size);
        if (size == '0) begin
            return 3'b000;
        end else if (size <= LED_R_MAX) begin
            return 3'b100;
        end else if (size <= LED_G_MAX) begin
            return 3'b010;
        end else begin
            return 3'b001;
        end
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic model_reset();
        m_app         = GRANT_NONE;
        m_rx_eng      = 1'b1;
        m_rx_host_rel = 1'b0;
        m_tx_eng      = 1'b0;
        m_edges       = 0;
        m_rdata       = '0;
        m_size        = '0;
    endtask

    // one rising edge of the model on the inputs held across it.
    task automatic model_update();
        logic tx_host_rel;
        logic rx_host_rel;
        int   idx;
        tx_host_rel = (m_edges > 0) && (m_edges % TX_PERIOD == 0);
        rx_host_rel = m_rx_host_rel;
        case (m_app)
            GRANT_NONE: begin
                if (app_data_ip_req) begin
                    m_app = GRANT_ENGINE;
                end else if (app_data_cpu_req) begin
                    m_app = GRANT_HOST;
                end
            end
            GRANT_ENGINE: begin
                if (app_data_ip_rel) begin
                    m_app = GRANT_NONE;
                end
            end
            default: begin
                if (app_data_cpu_rel) begin
                    m_app = GRANT_NONE;
                end
            end
        endcase
        // host hands the receive buffer back a cycle after it gets it.
        m_rx_host_rel = !m_rx_eng;
        if (m_rx_eng && rxbuf_ip_rel) begin
            m_rx_eng = 1'b0;
        end else if (!m_rx_eng && rx_host_rel) begin
            m_rx_eng = 1'b1;
        end
        if (m_tx_eng && txbuf_ip_rel) begin
            m_tx_eng = 1'b0;
        end else if (!m_tx_eng && tx_host_rel) begin
            m_tx_eng = 1'b1;
        end
        m_edges++;
        idx = int'(txbuf_addr);
        m_rdata = (idx < TX_RECORD_LEN) ? TX_RECORD[idx] : '0;
        if (rxbuf_ce && rxbuf_we && (rxbuf_addr == SIZE_WORD_ADDR)) begin
            m_size = rxbuf_wdata[WORD_WIDTH-1 -: SIZE_WIDTH];
        end
    endtask

    task automatic check_outputs();
        logic [2:0] leds;
        leds = expected_leds(m_size);
        check_bit("app_data_ip_grant", app_data_ip_grant, m_app == GRANT_ENGINE);
        check_bit("app_data_cpu_grant", app_data_cpu_grant, m_app == GRANT_HOST);
        check_bit("rxbuf_ip_grant", rxbuf_ip_grant, m_rx_eng);
        check_bit("txbuf_ip_grant", txbuf_ip_grant, m_tx_eng);
        check_word("txbuf_rdata", txbuf_rdata, m_rdata);
        check_bit("led_r", led_r, leds[2]);
        check_bit("led_g", led_g, leds[1]);
        check_bit("led_b", led_b, leds[0]);
    endtask

    task automatic step();
        @(posedge clk);
        #1;
        model_update();
        check_outputs();
    endtask

    task automatic idle_inputs();
        app_data_ip_req  = 1'b0;
        app_data_ip_rel  = 1'b0;
        app_data_cpu_req = 1'b0;
        app_data_cpu_rel = 1'b0;
        rxbuf_ip_rel     = 1'b0;
        rxbuf_addr       = '0;
        rxbuf_ce         = 1'b0;
        rxbuf_we         = 1'b0;
        rxbuf_wdata      = '0;
        txbuf_ip_rel     = 1'b0;
        txbuf_addr       = '0;
    endtask

    task automatic finish_test(input string name);
        step();
        idle_inputs();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %-12s %s, %0d errors", name, (test_errors == 0) ? "ok" : "bad",
                 test_errors);
        test_errors = 0;
    endtask

    task automatic run_app_test();
        logic [31:0] r;
        for (int i = 0; i < N_APP; i++) begin
            step();
            r = rand_word();
            app_data_ip_req  = r[0];
            app_data_cpu_req = r[1];
            app_data_ip_rel  = one_in(4);
            app_data_cpu_rel = one_in(4);
        end
        finish_test("app_data");
    endtask

    task automatic run_rx_test();
        int low_run;
        low_run = 0;
        for (int i = 0; i < N_RX; i++) begin
            step();
            if (!rxbuf_ip_grant) begin
                low_run++;
            end else if (low_run != 0) begin
                assert (low_run == 2) else begin
                    $display("mismatch at %0t: rxbuf_ip_grant low cycles got %0d expected 2",
                             $time, low_run);
                    errors++;
                    test_errors++;
                end
                low_run = 0;
            end
            rxbuf_ip_rel = one_in(3);
        end
        finish_test("rx_return");
    endtask

    task automatic run_tx_test();
        for (int i = 0; i < N_TX; i++) begin
            step();
            txbuf_ip_rel = one_in(20);
        end
        finish_test("tx_handover");
    endtask

    task automatic run_rec_test();
        logic [31:0] r;
        for (int i = 0; i < N_REC; i++) begin
            step();
            r = rand_word();
            txbuf_addr = r[9] ? {3'b000, r[2:0]} : r[8:3];
        end
        finish_test("tx_record");
    endtask

    task automatic run_led_test();
        logic [31:0]           r;
        logic [SIZE_WIDTH-1:0] size;
        for (int i = 0; i < N_LED; i++) begin
            step();
            r = rand_word();
            // sizes on both sides of each threshold.
            case (r[2:0])
                3'd0:    size = 16'd0;
                3'd1:    size = 16'd1;
                3'd2:    size = LED_R_MAX;
                3'd3:    size = LED_R_MAX + 16'd1;
                3'd4:    size = LED_G_MAX;
                3'd5:    size = LED_G_MAX + 16'd1;
                default: size = r[31:16];
            endcase
            rxbuf_ce    = !one_in(4);
            rxbuf_we    = !one_in(4);
            rxbuf_addr  = r[3] ? SIZE_WORD_ADDR : r[9:4];
            rxbuf_wdata = {size, r[25:10]};
        end
        finish_test("size_leds");
    endtask

    initial begin
        rst_n        = 1'b0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        idle_inputs();
        model_reset();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // reset values before the first active edge.
        check_outputs();
        finish_test("reset");
        run_app_test();
        run_rx_test();
        run_tx_test();
        run_rec_test();
        run_led_test();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
src/ros2_cfg_pkg.sv
src/buf_arb_pkg.sv
src/rxbuf_wr_if.sv
src/app_data_arbiter.sv
src/buf_owner_arbiter.sv
src/host_tx_agent.sv
src/host_rx_agent.sv
src/ros2_buf_ctrl_top.sv
sim/buf_ctrl_props.sv
sim/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
